// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbRtcController
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/rtcSlaveModel.sv ====
`default_nettype none

module rtcSlaveModel (
	input logic CLK,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input rtcPkg::rtcAddr_t wbAdr,
	input rtcPkg::rtcReg_t wbDatW,
	output rtcPkg::rtcReg_t wbDatR,
	output logic wbAck,
	input logic pokeEn, // Backdoor register write
	input rtcPkg::rtcAddr_t pokeAddr,
	input rtcPkg::rtcReg_t pokeData
);
	timeunit 1ns;
	timeprecision 1ps;
	import rtcPkg::*;

	rtcReg_t regs [0:255];
	rtcAddr_t logAddr [0:255]; // Bus writes in order
	rtcReg_t logData [0:255];
	logic [7:0] logCount;
	int waitCnt;
	logic inCycle;

	always @(posedge CLK)
	begin
		if (reset)
		begin
			wbAck <= 1'b0;
			wbDatR <= '0;
			inCycle <= 1'b0;
			waitCnt <= 0;
			logCount <= '0;
			for (int i = 0; i < 256; i++)
				regs[i[7:0]] <= i[7:0] ^ 8'hA5;
		end
		else
		begin
			wbAck <= 1'b0;
			if (pokeEn)
				regs[pokeAddr] <= pokeData;
			if (wbCyc && wbStb && !wbAck)
			begin
				if (!inCycle)
				begin
					inCycle <= 1'b1;
					waitCnt <= $urandom_range(5, 0); // Random stall
				end
				else if (waitCnt > 0)
					waitCnt <= waitCnt - 1;
				else
				begin
					inCycle <= 1'b0;
					wbAck <= 1'b1;
					wbDatR <= regs[wbAdr];
					if (wbWe)
					begin
						regs[wbAdr] <= wbDatW;
						logAddr[logCount] <= wbAdr;
						logData[logCount] <= wbDatW;
						logCount <= logCount + 8'd1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/tbRtcController.sv ====
`default_nettype none

module tbRtcController;
	timeunit 1ns;
	timeprecision 1ps;
	import rtcPkg::*;

	localparam int SEED = 30719;
	localparam int TIMEOUT_CYCLES = 500;

	typedef enum {evClear, evPoke, evUser} timeEvent_t;

	logic CLK;
	logic reset;
	logic refreshReq;
	logic userReq;
	timeVal_t userTime;
	timeVal_t timeOut;
	logic timeValid;
	logic userAck;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	rtcAddr_t wbAdr;
	rtcReg_t wbDatW;
	rtcReg_t wbDatR;
	logic wbAck;
	logic pokeEn;
	rtcAddr_t pokeAddr;
	rtcReg_t pokeData;

	int errorCount;
	int timeErrors;
	int busErrors;
	int timeoutCount;
	int timeChecks;
	string testName;
	timeEvent_t lastEvent;
	timeVal_t pokeTime;
	timeVal_t ackedUser;
	timeVal_t newTime;
	logic monActive;
	rtcAddr_t monAdr;
	logic monWe;
	rtcReg_t monDat;

	rtcControllerTop u_dut (
		.CLK(CLK),
		.reset(reset),
		.refreshReq(refreshReq),
		.userReq(userReq),
		.userTime(userTime),
		.timeOut(timeOut),
		.timeValid(timeValid),
		.userAck(userAck),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

	rtcSlaveModel u_slave (
		.CLK(CLK),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.pokeEn(pokeEn),
		.pokeAddr(pokeAddr),
		.pokeData(pokeData)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#4 CLK = ~CLK;
	end

	// Time the chip should hold after the latest event
	function automatic timeVal_t expectTime(input timeEvent_t ev, input timeVal_t backdoor,
		input timeVal_t user);
		case (ev)
			evPoke: return backdoor;
			evUser: return user;
			default: return '0; // Clear phase wrote zeros
		endcase
	endfunction

	task automatic checkReg(input string name, input rtcReg_t expected, input rtcReg_t actual,
		inout int errors);
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: expected %02h, actual %02h", name, expected, actual);
		end
	endtask

	task automatic checkTime(input string name, input timeVal_t expected,
		input timeVal_t actual, inout int errors);
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: expected %06h, actual %06h", name, expected, actual);
		end
	endtask

	task automatic reportProblem(input string msg, inout int errors);
		errors++;
		$display("%s", msg);
	endtask

	task automatic checkResetState(input string name);
		if (wbCyc !== 1'b0 || wbStb !== 1'b0)
			reportProblem({name, ": a bus cycle is active"}, errorCount);
		if (timeValid !== 1'b0 || userAck !== 1'b0)
			reportProblem({name, ": timeValid or userAck is high"}, errorCount);
		checkTime(name, '0, timeOut, errorCount);
	endtask

	task automatic checkWrite(input string name, input logic [7:0] idx, input rtcAddr_t addr,
		input rtcReg_t data);
		checkReg({name, " address"}, addr, u_slave.logAddr[idx], errorCount);
		checkReg({name, " data"}, data, u_slave.logData[idx], errorCount);
	endtask

	task automatic waitForTimeValid(input string what);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
		end
		while (!timeValid && cycles < TIMEOUT_CYCLES);
		if (!timeValid)
		begin
			timeoutCount++;
			$display("Timeout: timeValid never came for %s", what);
		end
	endtask

	task automatic waitForUserAck(input string what);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
		end
		while (!userAck && cycles < TIMEOUT_CYCLES);
		if (!userAck)
		begin
			timeoutCount++;
			$display("Timeout: userAck never came for %s", what);
		end
	endtask

	task automatic writeBackdoor(input rtcAddr_t addr, input rtcReg_t data);
		pokeEn <= 1'b1;
		pokeAddr <= addr;
		pokeData <= data;
		@(posedge CLK);
	endtask

	// Every published time against the reference
	always @(negedge CLK)
	begin
		if (!reset && timeValid)
		begin
			timeChecks++;
			checkTime(testName, expectTime(lastEvent, pokeTime, ackedUser), timeOut, timeErrors);
		end
	end

	always @(negedge CLK)
	begin
		if (reset)
			monActive = 1'b0;
		else
		begin
			if (wbCyc !== wbStb)
				reportProblem("wbCyc and wbStb are not asserted together", busErrors);
			if (!wbCyc)
				monActive = 1'b0;
			else
			begin
				if (!monActive)
				begin
					monActive = 1'b1; // Cycle start
					monAdr = wbAdr;
					monWe = wbWe;
					monDat = wbDatW;
				end
				else if (wbAdr !== monAdr || wbWe !== monWe || wbDatW !== monDat)
					reportProblem("bus address, direction or data changed before ack", busErrors);
				if (wbAck)
					monActive = 1'b0;
			end
		end
	end

	initial
	begin
		void'($urandom(SEED));
		errorCount = 0;
		timeErrors = 0;
		busErrors = 0;
		timeoutCount = 0;
		timeChecks = 0;
		testName = "clear and first read";
		lastEvent = evClear;
		pokeTime = '0;
		ackedUser = '0;
		monActive = 1'b0;
		reset = 1'b1;
		refreshReq = 1'b0;
		userReq = 1'b0;
		userTime = '0;
		pokeEn = 1'b0;
		pokeAddr = '0;
		pokeData = '0;

		repeat (3) @(posedge CLK);
		@(negedge CLK);
		checkResetState("during reset");
		@(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		checkResetState("after reset");

		waitForTimeValid("the first read");
		if (u_slave.logCount < 8'd5)
			reportProblem("fewer than five writes came before the first read", errorCount);
		checkWrite("init control", 8'd0, ADDR_CONTROL, CTRL_INIT);
		checkWrite("init status", 8'd1, ADDR_STATUS, STATUS_INIT);
		checkWrite("clear seconds", 8'd2, ADDR_SECONDS, 8'h00);
		checkWrite("clear minutes", 8'd3, ADDR_MINUTES, 8'h00);
		checkWrite("clear hours", 8'd4, ADDR_HOURS, 8'h00);

		@(posedge CLK);
		testName = "refresh read";
		pokeTime = timeVal_t'($urandom);
		lastEvent = evPoke;
		writeBackdoor(ADDR_SECONDS, pokeTime.seconds);
		writeBackdoor(ADDR_MINUTES, pokeTime.minutes);
		writeBackdoor(ADDR_HOURS, pokeTime.hours);
		pokeEn <= 1'b0;
		refreshReq <= 1'b1; // One-cycle pulse
		@(posedge CLK);
		refreshReq <= 1'b0;
		waitForTimeValid("the refresh read");

		@(posedge CLK);
		testName = "user write";
		newTime = timeVal_t'($urandom);
		userTime <= newTime;
		userReq <= 1'b1;
		waitForUserAck("the user write");
		ackedUser = newTime;
		lastEvent = evUser;
		checkReg("user write seconds", newTime.seconds, u_slave.regs[ADDR_SECONDS], errorCount);
		checkReg("user write minutes", newTime.minutes, u_slave.regs[ADDR_MINUTES], errorCount);
		checkReg("user write hours", newTime.hours, u_slave.regs[ADDR_HOURS], errorCount);
		@(posedge CLK);
		userReq <= 1'b0;
		waitForTimeValid("the read after the user write");

		repeat (4) @(posedge CLK);
		if (timeChecks != 3)
			reportProblem("the time compare did not see exactly three reads", errorCount);
		errorCount = errorCount + timeErrors + busErrors;
		$display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
src/rtcPkg.sv
src/mainControl.sv
src/initSequencer.sv
src/timeWriter.sv
src/timeReader.sv
src/rtcBusMaster.sv
src/rtcControllerTop.sv
dv/rtcSlaveModel.sv
dv/tbRtcController.sv

// ==== src/initSequencer.sv ====
`default_nettype none

module initSequencer (
	input logic CLK,
	input logic reset,
	input logic en,
	output rtcPkg::busReq_t req,
	input rtcPkg::busRsp_t rsp,
	output logic done
);
	import rtcPkg::*;

	logic enPrev;
	logic busy;
	logic step; // 0 control, 1 status

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			enPrev <= 1'b0;
			busy <= 1'b0;
			step <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			enPrev <= en;
			done <= 1'b0;
			if (en && !enPrev && !busy)
			begin
				busy <= 1'b1;
				step <= 1'b0;
			end
			else if (busy && rsp.done)
			begin
				step <= 1'b1;
				if (step)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_comb
	begin
		req.valid = busy;
		req.we = 1'b1;
		req.addr = step ? ADDR_STATUS : ADDR_CONTROL;
		req.wdata = step ? STATUS_INIT : CTRL_INIT;
	end

endmodule

`default_nettype wire

// ==== src/mainControl.sv ====
`default_nettype none

module mainControl (
	input logic CLK,
	input logic reset,
	input logic initDone,
	input logic writeDone,
	input logic readDone,
	input logic refreshReq,
	input logic userReq,
	output logic initEn,
	output logic writeEn,
	output logic clearSel,
	output logic readEn,
	output logic userAck
);
	import rtcPkg::*;

	mainState_t state;
	mainState_t nextState;

	always_comb
	begin
		nextState = state;
		case (state)
			stInit:
				if (initDone)
					nextState = stClear;
			stClear:
				if (writeDone)
					nextState = stRead;
			stRead:
				if (readDone)
					nextState = stIdle;
			stIdle:
				// A pending user write also wakes the loop
				if (refreshReq || userReq)
					nextState = stRequest;
			stRequest:
				if (userReq)
					nextState = stUserWrite;
				else
					nextState = stRead;
			stUserWrite:
				if (writeDone)
					nextState = stRead;
			default:
				nextState = stInit;
		endcase
	end

	// Enables decode the current state, one cycle late
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= stInit;
			initEn <= 1'b0;
			writeEn <= 1'b0;
			clearSel <= 1'b0;
			readEn <= 1'b0;
		end
		else
		begin
			state <= nextState;
			initEn <= (state == stInit);
			writeEn <= (state == stClear) || (state == stUserWrite);
			clearSel <= (state == stClear); // Zero data in clear phase
			readEn <= (state == stRead);
		end
	end

	assign userAck = writeDone && (state == stUserWrite);

	// Sequencers share one bus master
	assert property (@(posedge CLK) disable iff (reset)
		$onehot0({initEn, writeEn, readEn}))
	else
		$error("mainControl: more than one sequencer enabled");

endmodule

`default_nettype wire

// ==== src/rtcBusMaster.sv ====
`default_nettype none

module rtcBusMaster (
	input logic CLK,
	input logic reset,
	input rtcPkg::busReq_t initReq,
	input rtcPkg::busReq_t writeReq,
	input rtcPkg::busReq_t readReq,
	output rtcPkg::busRsp_t rsp,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output rtcPkg::rtcAddr_t wbAdr,
	output rtcPkg::rtcReg_t wbDatW,
	input rtcPkg::rtcReg_t wbDatR,
	input logic wbAck
);
	import rtcPkg::*;

	typedef enum logic {
		busIdle,
		busCycle
	} busState_t;

	busState_t state;
	busReq_t sel;
	logic accept;
	logic rspDone;
	rtcReg_t rspData;

	// Requests are one-hot, so priority order is arbitrary
	always_comb
	begin
		if (initReq.valid)
			sel = initReq;
		else if (writeReq.valid)
			sel = writeReq;
		else
			sel = readReq;
	end

	// The finished request is still valid while done is high
	assign accept = (state == busIdle) && sel.valid && !rspDone;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= busIdle;
			rspDone <= 1'b0;
		end
		else
		begin
			rspDone <= 1'b0;
			case (state)
				busIdle:
					if (accept)
						state <= busCycle;
				busCycle:
					if (wbAck)
					begin
						state <= busIdle;
						rspDone <= 1'b1;
					end
				default:
					state <= busIdle;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			wbAdr <= sel.addr;
			wbWe <= sel.we;
			wbDatW <= sel.wdata;
		end
		if (state == busCycle && wbAck)
			rspData <= wbDatR;
	end

	assign wbCyc = (state == busCycle);
	assign wbStb = (state == busCycle);
	assign rsp = '{done: rspDone, rdata: rspData};

	assert property (@(posedge CLK) disable iff (reset)
		$onehot0({initReq.valid, writeReq.valid, readReq.valid}))
	else
		$error("rtcBusMaster: several requesters active at once");

	// Cycle held unchanged until the chip acks
	assert property (@(posedge CLK) disable iff (reset)
		(wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
	else
		$error("rtcBusMaster: cycle changed before ack");

endmodule

`default_nettype wire

// ==== src/rtcControllerTop.sv ====
`default_nettype none

module rtcControllerTop (
	input logic CLK,
	input logic reset,
	input logic refreshReq,
	input logic userReq,
	input rtcPkg::timeVal_t userTime,
	output rtcPkg::timeVal_t timeOut,
	output logic timeValid,
	output logic userAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output rtcPkg::rtcAddr_t wbAdr,
	output rtcPkg::rtcReg_t wbDatW,
	input rtcPkg::rtcReg_t wbDatR,
	input logic wbAck
);
	import rtcPkg::*;

	logic initEn;
	logic writeEn;
	logic clearSel;
	logic readEn;
	logic initDone;
	logic writeDone;
	logic readDone;
	busReq_t initReq;
	busReq_t writeReq;
	busReq_t readReq;
	busRsp_t busRsp; // Shared by all three sequencers

	mainControl u_mainControl (
		.CLK(CLK),
		.reset(reset),
		.initDone(initDone),
		.writeDone(writeDone),
		.readDone(readDone),
		.refreshReq(refreshReq),
		.userReq(userReq),
		.initEn(initEn),
		.writeEn(writeEn),
		.clearSel(clearSel),
		.readEn(readEn),
		.userAck(userAck)
	);

	initSequencer u_initSequencer (
		.CLK(CLK),
		.reset(reset),
		.en(initEn),
		.req(initReq),
		.rsp(busRsp),
		.done(initDone)
	);

	timeWriter u_timeWriter (
		.CLK(CLK),
		.reset(reset),
		.en(writeEn),
		.clearSel(clearSel),
		.userTime(userTime),
		.req(writeReq),
		.rsp(busRsp),
		.done(writeDone)
	);

	timeReader u_timeReader (
		.CLK(CLK),
		.reset(reset),
		.en(readEn),
		.req(readReq),
		.rsp(busRsp),
		.timeOut(timeOut),
		.timeValid(timeValid),
		.done(readDone)
	);

	rtcBusMaster u_rtcBusMaster (
		.CLK(CLK),
		.reset(reset),
		.initReq(initReq),
		.writeReq(writeReq),
		.readReq(readReq),
		.rsp(busRsp),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

endmodule

`default_nettype wire

// ==== src/rtcPkg.sv ====
`default_nettype none

package rtcPkg;

	typedef logic [7:0] rtcReg_t; // Chip register data
	typedef logic [7:0] rtcAddr_t; // Chip register address

	// Seconds sits in the top byte
	typedef struct packed {
		rtcReg_t seconds;
		rtcReg_t minutes;
		rtcReg_t hours;
	} timeVal_t;

	typedef struct packed {
		logic valid;
		logic we;
		rtcAddr_t addr;
		rtcReg_t wdata;
	} busReq_t;

	typedef struct packed {
		logic done; // One-cycle pulse
		rtcReg_t rdata;
	} busRsp_t;

	typedef enum logic [2:0] {
		stInit,
		stClear,
		stRead,
		stIdle,
		stRequest,
		stUserWrite
	} mainState_t;

	// Configuration registers
	localparam rtcAddr_t ADDR_CONTROL = 8'h02;
	localparam rtcReg_t CTRL_INIT = 8'h10;
	localparam rtcAddr_t ADDR_STATUS = 8'h01;
	localparam rtcReg_t STATUS_INIT = 8'h00;

	// Time registers
	localparam rtcAddr_t ADDR_SECONDS = 8'h21;
	localparam rtcAddr_t ADDR_MINUTES = 8'h22;
	localparam rtcAddr_t ADDR_HOURS = 8'h23;

endpackage

`default_nettype wire

// ==== src/timeReader.sv ====
`default_nettype none

module timeReader (
	input logic CLK,
	input logic reset,
	input logic en,
	output rtcPkg::busReq_t req,
	input rtcPkg::busRsp_t rsp,
	output rtcPkg::timeVal_t timeOut,
	output logic timeValid,
	output logic done
);
	import rtcPkg::*;

	logic enPrev;
	logic busy;
	logic [1:0] step;
	rtcReg_t shadowSec; // Held until hours arrive
	rtcReg_t shadowMin;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			enPrev <= 1'b0;
			busy <= 1'b0;
			step <= 2'd0;
			done <= 1'b0;
			timeValid <= 1'b0;
			timeOut <= '0;
		end
		else
		begin
			enPrev <= en;
			done <= 1'b0;
			timeValid <= 1'b0;
			if (en && !enPrev && !busy)
			begin
				busy <= 1'b1;
				step <= 2'd0;
			end
			else if (busy && rsp.done)
			begin
				step <= step + 2'd1;
				if (step == 2'd2)
				begin
					busy <= 1'b0;
					done <= 1'b1;
					timeValid <= 1'b1;
					timeOut <= '{seconds: shadowSec, minutes: shadowMin,
						hours: rsp.rdata};
				end
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (busy && rsp.done)
		begin
			case (step)
				2'd0: shadowSec <= rsp.rdata;
				2'd1: shadowMin <= rsp.rdata;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		req.valid = busy;
		req.we = 1'b0;
		req.wdata = '0;
		case (step)
			2'd0: req.addr = ADDR_SECONDS;
			2'd1: req.addr = ADDR_MINUTES;
			default: req.addr = ADDR_HOURS;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/timeWriter.sv ====
`default_nettype none

module timeWriter (
	input logic CLK,
	input logic reset,
	input logic en,
	input logic clearSel,
	input rtcPkg::timeVal_t userTime,
	output rtcPkg::busReq_t req,
	input rtcPkg::busRsp_t rsp,
	output logic done
);
	import rtcPkg::*;

	logic enPrev;
	logic busy;
	logic [1:0] step; // Seconds, minutes, hours
	logic start;
	timeVal_t wrTime;

	assign start = en && !enPrev && !busy;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			enPrev <= 1'b0;
			busy <= 1'b0;
			step <= 2'd0;
			done <= 1'b0;
		end
		else
		begin
			enPrev <= en;
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				step <= 2'd0;
			end
			else if (busy && rsp.done)
			begin
				step <= step + 2'd1;
				if (step == 2'd2)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Held for the whole sequence
	always_ff @(posedge CLK)
	begin
		if (start)
			wrTime <= clearSel ? '0 : userTime;
	end

	always_comb
	begin
		req.valid = busy;
		req.we = 1'b1;
		case (step)
			2'd0:
			begin
				req.addr = ADDR_SECONDS;
				req.wdata = wrTime.seconds;
			end
			2'd1:
			begin
				req.addr = ADDR_MINUTES;
				req.wdata = wrTime.minutes;
			end
			default:
			begin
				req.addr = ADDR_HOURS;
				req.wdata = wrTime.hours;
			end
		endcase
	end

endmodule

`default_nettype wire
